// File: project.f
+incdir+verilog
verilog/usb_ep_pkg.sv
verilog/usb_link_pkg.sv
verilog/packet_fifo.sv
verilog/ep_bulk_in.sv
verilog/ep_tx_arbiter.sv
verilog/usb_in_top.sv
tb/usb_in_chk.sv
tb/tb_usb_in.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the USB bulk IN testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_usb_in -f project.f -o tb_usb_in > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

# Assertion errors must not end the run before the testbench reports them
./obj_dir/tb_usb_in +verilator+error+limit+100 > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -q -- "=== PASS ===" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

// File: tb/tb_usb_in.sv
`include "usb_ep_settings.svh"

module tb_usb_in;

  localparam int MAXP = `USB_EP_MAX_PACKET;

  logic                  clock;
  logic                  rst_i;
  logic                  token_i;
  usb_link_pkg::ep_num_t token_ep_i;
  logic                  ack_i;
  logic                  timeout_i;
  logic                  set_conf_i;
  logic                  clr_conf_i;
  logic                  ep0_s_tvalid_i;
  logic                  ep0_s_tready_o;
  logic                  ep0_s_tlast_i;
  usb_ep_pkg::byte_t     ep0_s_tdata_i;
  logic                  ep1_s_tvalid_i;
  logic                  ep1_s_tready_o;
  logic                  ep1_s_tlast_i;
  usb_ep_pkg::byte_t     ep1_s_tdata_i;
  logic                  m_tvalid_o;
  logic                  m_tready_i;
  logic                  m_tkeep_o;
  logic                  m_tlast_o;
  usb_ep_pkg::byte_t     m_tdata_o;
  logic                  parity_o;
  logic [1:0]            ep_ready;
  logic [1:0]            stalled;

  integer seed = 32'hc40c6440;

  // Expected bytes, chunk lengths and parity per endpoint
  // A ZDP is listed with length 0
  usb_ep_pkg::byte_t exp_bytes [2][$];
  int                exp_lens [2][$];
  logic              exp_par [2];

  usb_in_top dut0 (
    .clock         (clock),
    .rst_i         (rst_i),
    .token_i       (token_i),
    .token_ep_i    (token_ep_i),
    .ack_i         (ack_i),
    .timeout_i     (timeout_i),
    .set_conf_i    (set_conf_i),
    .clr_conf_i    (clr_conf_i),
    .ep0_s_tvalid_i(ep0_s_tvalid_i),
    .ep0_s_tready_o(ep0_s_tready_o),
    .ep0_s_tlast_i (ep0_s_tlast_i),
    .ep0_s_tdata_i (ep0_s_tdata_i),
    .ep1_s_tvalid_i(ep1_s_tvalid_i),
    .ep1_s_tready_o(ep1_s_tready_o),
    .ep1_s_tlast_i (ep1_s_tlast_i),
    .ep1_s_tdata_i (ep1_s_tdata_i),
    .m_tvalid_o    (m_tvalid_o),
    .m_tready_i    (m_tready_i),
    .m_tkeep_o     (m_tkeep_o),
    .m_tlast_o     (m_tlast_o),
    .m_tdata_o     (m_tdata_o),
    .parity_o      (parity_o),
    .ep_ready_o    (ep_ready),
    .stalled_o     (stalled)
  );

  bind usb_in_top usb_in_chk chk0 (
    .clock       (clock),
    .rst_i       (rst_i),
    .token_i     (token_i),
    .token_ep_i  (token_ep_i),
    .ack_i       (ack_i),
    .timeout_i   (timeout_i),
    .tvalid_i    (m_tvalid_o),
    .tready_i    (m_tready_i),
    .tkeep_i     (m_tkeep_o),
    .tlast_i     (m_tlast_o),
    .tdata_i     (m_tdata_o),
    .parity_i    (parity_o),
    .ep_ready_i  (ep_ready_o),
    .stalled_i   (stalled_o),
    .src0_ready_i(ep0_s_tready_o),
    .src1_ready_i(ep1_s_tready_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic report_mismatch(input string msg);
    stop_run($sformatf("[ERROR] %0t: %s", $time, msg));
  endtask

  // Checker flags are polled between edges
  always @(negedge clock) begin
    if (dut0.chk0.failed) begin
      stop_run("A concurrent assertion in the checker failed");
    end
  end

  task automatic drive_source(input bit ep, input logic v, input logic l,
                              input usb_ep_pkg::byte_t d);
    if (ep == 1'b0) begin
      ep0_s_tvalid_i = v;
      ep0_s_tlast_i  = l;
      ep0_s_tdata_i  = d;
    end else begin
      ep1_s_tvalid_i = v;
      ep1_s_tlast_i  = l;
      ep1_s_tdata_i  = d;
    end
  endtask

  // Push one frame of random bytes and note the chunks it must leave as
  task automatic send_frame(input bit ep, input int len);
    usb_ep_pkg::byte_t b;
    logic taken;
    int n;
    for (int i = 0; i < len; i++) begin
      b = usb_ep_pkg::byte_t'($random(seed));
      exp_bytes[ep].push_back(b);
      if (i % MAXP == MAXP - 1 || i == len - 1) begin
        exp_lens[ep].push_back(i % MAXP + 1);
      end
      drive_source(ep, 1'b1, i == len - 1, b);
      taken = 1'b0;
      n = 0;
      while (!taken) begin
        @(negedge clock);
        taken = ep ? ep1_s_tready_o : ep0_s_tready_o;
        @(posedge clock);
        #1;
        n++;
        if (n > 100) begin
          stop_run("Timeout: the endpoint never accepted a source byte");
        end
      end
    end
    drive_source(ep, 1'b0, 1'b0, 8'h00);
    // Frame ending on a chunk boundary owes a ZDP
    if (len % MAXP == 0) begin
      exp_lens[ep].push_back(0);
    end
  endtask

  task automatic send_token(input usb_link_pkg::ep_num_t ep);
    token_i    = 1'b1;
    token_ep_i = ep;
    @(posedge clock);
    #1;
    token_i = 1'b0;
  endtask

  // Token for a missing or stalled endpoint must leave the link idle
  task automatic expect_silence(input usb_link_pkg::ep_num_t ep);
    send_token(ep);
    repeat (8) begin
      @(negedge clock);
      assert (!m_tvalid_o) else report_mismatch($sformatf("beat after token for ep%0d", ep));
      @(posedge clock);
      #1;
    end
  endtask

  // One IN transaction with token, throttled packet and then ACK or timeout
  task automatic in_transaction(input bit ep, input logic acked);
    usb_ep_pkg::byte_t got [$];
    logic [31:0] rnd;
    logic zdp;
    logic par;
    logic done;
    int len;
    int n;
    len = exp_lens[ep][0];
    n = 0;
    while (!ep_ready[ep]) begin
      @(posedge clock);
      #1;
      n++;
      if (n > 50) begin
        stop_run("Timeout: the endpoint never reported a pending packet");
      end
    end
    send_token(usb_link_pkg::ep_num_t'(ep));
    done = 1'b0;
    zdp  = 1'b0;
    par  = 1'b0;
    n    = 0;
    while (!done) begin
      rnd = $random(seed);
      m_tready_i = rnd[1:0] != 2'b00;
      @(negedge clock);
      if (m_tvalid_o && m_tready_i) begin
        par  = parity_o;
        done = m_tlast_o;
        if (m_tkeep_o) begin
          got.push_back(m_tdata_o);
        end else begin
          zdp = 1'b1;
        end
      end
      @(posedge clock);
      #1;
      n++;
      if (n > 100) begin
        stop_run("Timeout: the packet never ended with last");
      end
    end
    m_tready_i = 1'b0;
    assert (got.size() == len && zdp == (len == 0))
      else report_mismatch($sformatf("ep%0d sent %0d bytes, expected %0d",
                                     ep, got.size(), len));
    foreach (got[i]) begin
      assert (got[i] == exp_bytes[ep][i])
        else report_mismatch($sformatf("ep%0d byte %0d is %h, expected %h",
                                       ep, i, got[i], exp_bytes[ep][i]));
    end
    assert (par == exp_par[ep])
      else report_mismatch($sformatf("ep%0d parity %0b, expected %0b",
                                     ep, par, exp_par[ep]));
    if (acked) begin
      ack_i = 1'b1;
    end else begin
      timeout_i = 1'b1;
    end
    @(posedge clock);
    #1;
    ack_i     = 1'b0;
    timeout_i = 1'b0;
    // Only an ACK retires the chunk
    // A timeout keeps it for the resend
    if (acked) begin
      repeat (len) exp_bytes[ep].delete(0);
      exp_lens[ep].delete(0);
      exp_par[ep] = !exp_par[ep];
    end
  endtask

  initial begin
    rst_i      = 1'b1;
    token_i    = 1'b0;
    token_ep_i = '0;
    ack_i      = 1'b0;
    timeout_i  = 1'b0;
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    m_tready_i = 1'b0;
    drive_source(1'b0, 1'b0, 1'b0, 8'h00);
    drive_source(1'b1, 1'b0, 1'b0, 8'h00);
    exp_par[0] = 1'b0;
    exp_par[1] = 1'b0;
    repeat (5) @(posedge clock);
    #1;
    rst_i = 1'b0;

    // Unconfigured endpoints ignore offered source data and a token
    drive_source(1'b0, 1'b1, 1'b1, 8'h5a);
    drive_source(1'b1, 1'b1, 1'b1, 8'ha5);
    m_tready_i = 1'b1;
    expect_silence(4'd0);
    @(negedge clock);
    assert (stalled == 2'b11 && ep_ready == 2'b00 && !ep0_s_tready_o && !ep1_s_tready_o)
      else report_mismatch($sformatf("stalled %b ready %b source ready %b%b unconfigured",
                                     stalled, ep_ready, ep1_s_tready_o, ep0_s_tready_o));
    @(posedge clock);
    #1;
    drive_source(1'b0, 1'b0, 1'b0, 8'h00);
    drive_source(1'b1, 1'b0, 1'b0, 8'h00);
    m_tready_i = 1'b0;

    set_conf_i = 1'b1;
    @(posedge clock);
    #1;
    set_conf_i = 1'b0;
    @(negedge clock);
    assert (stalled == 2'b00)
      else report_mismatch($sformatf("stalled %b after configuration", stalled));
    @(posedge clock);
    #1;

    // 20 bytes as 8, 8 and 4 with the second chunk resent after a timeout
    send_frame(1'b0, 20);
    in_transaction(1'b0, 1'b1);
    in_transaction(1'b0, 1'b0);
    in_transaction(1'b0, 1'b1);
    in_transaction(1'b0, 1'b1);

    // 16 bytes owe a ZDP
    // Interleaved with traffic on the other endpoint
    send_frame(1'b0, 16);
    send_frame(1'b1, 11);
    in_transaction(1'b0, 1'b1);
    in_transaction(1'b1, 1'b1);
    expect_silence(4'd5);
    in_transaction(1'b0, 1'b1);
    in_transaction(1'b1, 1'b0);
    in_transaction(1'b1, 1'b1);
    in_transaction(1'b0, 1'b0);
    in_transaction(1'b0, 1'b1);

    repeat (4) @(posedge clock);
    if (!dut0.chk0.failed) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_run("A concurrent assertion in the checker failed");
    end
  end

endmodule

// File: tb/usb_in_chk.sv
`include "usb_ep_settings.svh"

module usb_in_chk (
  input logic                     clock,
  input logic                     rst_i,
  input logic                     token_i,
  input usb_link_pkg::ep_num_t    token_ep_i,
  input logic                     ack_i,
  input logic                     timeout_i,
  input logic                     tvalid_i,
  input logic                     tready_i,
  input logic                     tkeep_i,
  input logic                     tlast_i,
  input usb_ep_pkg::byte_t        tdata_i,
  input logic                     parity_i,
  input logic [`USB_EP_COUNT-1:0] ep_ready_i,
  input logic [`USB_EP_COUNT-1:0] stalled_i,
  input logic                     src0_ready_i,
  input logic                     src1_ready_i
);

  localparam int MAXP = `USB_EP_MAX_PACKET;

  // One flag per assertion, read by the testbench
  bit bad_stall;
  bit bad_len;
  bit bad_zdp;
  bit bad_hold;
  bit bad_par_pkt;
  bit bad_par_ack;
  bit bad_par_tmo;
  bit bad_owner;
  logic failed;

  usb_link_pkg::ep_num_t owner_q;
  int   beats_q;
  logic wait_q;
  logic beat_w;

  assign beat_w = tvalid_i && tready_i;
  assign failed = bad_stall | bad_len | bad_zdp | bad_hold |
                  bad_par_pkt | bad_par_ack | bad_par_tmo | bad_owner;

  // Owner of the link, beat index in the packet, handshake pending
  always_ff @(posedge clock) begin
    if (rst_i) begin
      owner_q <= '1;
      beats_q <= 0;
      wait_q  <= 1'b0;
    end else begin
      if (token_i) begin
        owner_q <= token_ep_i;
      end
      if (beat_w) begin
        beats_q <= tlast_i ? 0 : beats_q + 1;
      end
      if (beat_w && tlast_i) begin
        wait_q <= 1'b1;
      end else if (ack_i || timeout_i || token_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Unconfigured endpoints take nothing and send nothing
  stall_quiet: assert property (@(posedge clock) disable iff (rst_i)
    (&stalled_i) |-> !tvalid_i && !src0_ready_i && !src1_ready_i && ep_ready_i == '0)
    else begin
      bad_stall = 1'b1;
      $error("[ERROR] %0t: traffic while both endpoints are stalled", $time);
    end

  // Data beats stop at the maximum length and the last one carries last
  chunk_len: assert property (@(posedge clock) disable iff (rst_i)
    tvalid_i && tkeep_i |-> beats_q < MAXP - 1 || (beats_q == MAXP - 1 && tlast_i))
    else begin
      bad_len = 1'b1;
      $error("[ERROR] %0t: chunk longer than the maximum packet", $time);
    end

  // A ZDP is one lone beat
  zdp_beat: assert property (@(posedge clock) disable iff (rst_i)
    tvalid_i && !tkeep_i |-> tlast_i && beats_q == 0)
    else begin
      bad_zdp = 1'b1;
      $error("[ERROR] %0t: beat without keep inside a packet", $time);
    end

  stall_hold: assert property (@(posedge clock) disable iff (rst_i)
    tvalid_i && !tready_i |=>
      tvalid_i && $stable(tdata_i) && $stable(tlast_i) && $stable(tkeep_i))
    else begin
      bad_hold = 1'b1;
      $error("[ERROR] %0t: output beat changed while not ready", $time);
    end

  // DATA0/1 holds over a packet, flips on ACK, holds on timeout
  par_in_pkt: assert property (@(posedge clock) disable iff (rst_i)
    beat_w && !tlast_i |=> $stable(parity_i))
    else begin
      bad_par_pkt = 1'b1;
      $error("[ERROR] %0t: parity changed within a packet", $time);
    end

  par_on_ack: assert property (@(posedge clock) disable iff (rst_i)
    wait_q && ack_i |=> parity_i != $past(parity_i))
    else begin
      bad_par_ack = 1'b1;
      $error("[ERROR] %0t: parity did not toggle on ACK", $time);
    end

  par_on_tmo: assert property (@(posedge clock) disable iff (rst_i)
    wait_q && timeout_i |=> $stable(parity_i))
    else begin
      bad_par_tmo = 1'b1;
      $error("[ERROR] %0t: parity changed on timeout", $time);
    end

  // Unknown endpoint owns the link, so it must stay idle
  owner_idle: assert property (@(posedge clock) disable iff (rst_i)
    tvalid_i |-> owner_q < usb_link_pkg::ep_num_t'(`USB_EP_COUNT))
    else begin
      bad_owner = 1'b1;
      $error("[ERROR] %0t: beat while no endpoint owns the link", $time);
    end

endmodule

// File: verilog/ep_bulk_in.sv
`include "usb_ep_settings.svh"

module ep_bulk_in (
  input  logic              clock,
  input  logic              rst_i,

  input  logic              set_conf_i,
  input  logic              clr_conf_i,

  input  logic              selected_i,
  input  logic              ack_recv_i,
  input  logic              timedout_i,

  output logic              ep_ready_o,
  output logic              stalled_o,
  output logic              parity_o,

  input  logic              s_tvalid_i,
  output logic              s_tready_o,
  input  logic              s_tlast_i,
  input  usb_ep_pkg::byte_t s_tdata_i,

  output logic              m_tvalid_o,
  input  logic              m_tready_i,
  output logic              m_tkeep_o,
  output logic              m_tlast_o,
  output usb_ep_pkg::byte_t m_tdata_o
);

  localparam usb_ep_pkg::count_t CMAX    = '1;
  localparam usb_ep_pkg::level_t MAX_LVL = usb_ep_pkg::level_t'(`USB_EP_MAX_PACKET);
  // Highest level that still leaves room for one full chunk
  localparam usb_ep_pkg::level_t FULL_LVL =
      usb_ep_pkg::level_t'(`USB_EP_FIFO_DEPTH - `USB_EP_MAX_PACKET);

  usb_ep_pkg::rx_state_t rx_q;
  usb_ep_pkg::tx_state_t tx_q;
  usb_ep_pkg::tx_state_t tx_d;
  usb_ep_pkg::count_t    rcount_q;
  usb_ep_pkg::count_t    scount_q;
  usb_ep_pkg::level_t    level_w;

  logic set_q, par_q, zdp_q, owed_q, full_q;
  logic clear_w, rx_open_w, fifo_tready_w, fifo_tvalid_w, fifo_tlast_w, fifo_rd_w;
  logic wr_w, save_w, tok_w, next_w, redo_w, beat_w, zdp_set_w;

  // Any configuration change empties the FIFO
  assign clear_w    = rst_i || set_conf_i || clr_conf_i;
  assign stalled_o  = !set_q;
  assign parity_o   = par_q;
  assign ep_ready_o = fifo_tvalid_w || zdp_q;

  // Source stays blocked while a ZDP is owed, so the owed ZDP follows its frame
  assign rx_open_w  = rx_q == usb_ep_pkg::RX_RECV && !owed_q;
  assign s_tready_o = fifo_tready_w && rx_open_w;
  assign wr_w       = s_tvalid_i && s_tready_o;
  assign save_w     = wr_w && (s_tlast_i || rcount_q == CMAX);

  // Token alone, as opposed to a handshake routed to this endpoint
  assign tok_w  = selected_i && !ack_recv_i && !timedout_i;
  assign next_w = tx_q == usb_ep_pkg::TX_WAIT && selected_i && ack_recv_i;
  assign redo_w = tx_q == usb_ep_pkg::TX_WAIT && selected_i && timedout_i;

  // ZDP due once the ACKed full chunk was the last one of its frame
  assign zdp_set_w = next_w && !zdp_q && full_q && owed_q && level_w == MAX_LVL;

  assign m_tvalid_o = (tx_q == usb_ep_pkg::TX_SEND && fifo_tvalid_w) ||
                      tx_q == usb_ep_pkg::TX_NONE;
  assign m_tlast_o  = (tx_q == usb_ep_pkg::TX_SEND && fifo_tlast_w) ||
                      tx_q == usb_ep_pkg::TX_NONE;
  // ZDP beat carries no byte
  assign m_tkeep_o  = tx_q == usb_ep_pkg::TX_SEND;
  assign fifo_rd_w  = tx_q == usb_ep_pkg::TX_SEND && m_tready_i;
  assign beat_w     = fifo_rd_w && fifo_tvalid_w;

  // Configured flag
  always_ff @(posedge clock) begin
    if (rst_i || clr_conf_i) begin
      set_q <= 1'b0;
    end else if (set_conf_i) begin
      set_q <= 1'b1;
    end
  end

  // DATA0/1 toggle, restarts at DATA0 on configuration
  always_ff @(posedge clock) begin
    if (rst_i || set_conf_i) begin
      par_q <= 1'b0;
    end else if (next_w) begin
      par_q <= !par_q;
    end
  end

  // Receive counter, owed ZDP and receive FSM
  always_ff @(posedge clock) begin
    if (rst_i || clr_conf_i) begin
      rx_q     <= usb_ep_pkg::RX_HALT;
      rcount_q <= '0;
      owed_q   <= 1'b0;
    end else if (set_conf_i) begin
      rx_q     <= usb_ep_pkg::RX_RECV;
      rcount_q <= '0;
      owed_q   <= 1'b0;
    end else begin
      if (wr_w) begin
        rcount_q <= save_w ? '0 : rcount_q + 1'b1;
      end
      // Frame ended exactly on a chunk boundary
      if (save_w && s_tlast_i && rcount_q == CMAX) begin
        owed_q <= 1'b1;
      end else if (zdp_set_w) begin
        owed_q <= 1'b0;
      end
      case (rx_q)
        // Stop after a chunk that leaves less than a full chunk free
        usb_ep_pkg::RX_RECV: begin
          if (save_w && level_w >= FULL_LVL) begin
            rx_q <= usb_ep_pkg::RX_FULL;
          end
        end
        // Level only falls on ACK
        usb_ep_pkg::RX_FULL: begin
          if (level_w <= FULL_LVL) begin
            rx_q <= usb_ep_pkg::RX_RECV;
          end
        end
        default: rx_q <= rx_q;
      endcase
    end
  end

  // Transmit FSM next state
  always_comb begin
    tx_d = tx_q;
    case (tx_q)
      usb_ep_pkg::TX_IDLE: begin
        if (tok_w && zdp_q) begin
          tx_d = usb_ep_pkg::TX_NONE;
        end else if (tok_w && fifo_tvalid_w) begin
          tx_d = usb_ep_pkg::TX_SEND;
        end
      end
      usb_ep_pkg::TX_SEND: begin
        if (beat_w && fifo_tlast_w) begin
          tx_d = usb_ep_pkg::TX_WAIT;
        end
      end
      // Waiting for the host handshake
      usb_ep_pkg::TX_WAIT: begin
        if (next_w) begin
          tx_d = usb_ep_pkg::TX_IDLE;
        end else if (redo_w) begin
          tx_d = usb_ep_pkg::TX_REDO;
        end
      end
      // Single ZDP beat
      usb_ep_pkg::TX_NONE: begin
        if (m_tready_i) begin
          tx_d = usb_ep_pkg::TX_WAIT;
        end
      end
      // Rewound, resend the same packet on the next token
      usb_ep_pkg::TX_REDO: begin
        if (tok_w) begin
          tx_d = zdp_q ? usb_ep_pkg::TX_NONE : usb_ep_pkg::TX_SEND;
        end
      end
      default: tx_d = usb_ep_pkg::TX_IDLE;
    endcase
    if (!set_q) begin
      tx_d = usb_ep_pkg::TX_IDLE;
    end
  end

  // Transmit state, send counter and ZDP flag
  always_ff @(posedge clock) begin
    if (clear_w) begin
      tx_q     <= usb_ep_pkg::TX_IDLE;
      scount_q <= '0;
      full_q   <= 1'b0;
      zdp_q    <= 1'b0;
    end else begin
      tx_q <= tx_d;
      if (beat_w) begin
        scount_q <= fifo_tlast_w ? '0 : scount_q + 1'b1;
        // Remember whether the chunk just sent was full length
        if (fifo_tlast_w) begin
          full_q <= scount_q == CMAX;
        end
      end
      if (zdp_set_w) begin
        zdp_q <= 1'b1;
      end else if (next_w) begin
        zdp_q <= 1'b0;
      end
    end
  end

  packet_fifo u_fifo (
    .clock     (clock),
    .rst_i     (clear_w),
    .save_i    (save_w),
    .redo_i    (redo_w),
    .next_i    (next_w),
    .level_o   (level_w),
    .s_tvalid_i(s_tvalid_i && rx_open_w),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .s_tready_o(fifo_tready_w),
    .m_tvalid_o(fifo_tvalid_w),
    .m_tready_i(fifo_rd_w),
    .m_tlast_o (fifo_tlast_w),
    .m_tdata_o (m_tdata_o)
  );

endmodule

// File: verilog/ep_tx_arbiter.sv
`include "usb_ep_settings.svh"

module ep_tx_arbiter (
  input  logic                                  clock,
  input  logic                                  rst_i,

  input  logic                                  token_i,
  input  usb_link_pkg::ep_num_t                 token_ep_i,
  input  logic                                  ack_i,
  input  logic                                  timeout_i,

  output logic [`USB_EP_COUNT-1:0]              ep_selected_o,
  output logic [`USB_EP_COUNT-1:0]              ep_ack_o,
  output logic [`USB_EP_COUNT-1:0]              ep_timeout_o,

  input  logic [`USB_EP_COUNT-1:0]              ep_tvalid_i,
  input  logic [`USB_EP_COUNT-1:0]              ep_tkeep_i,
  input  logic [`USB_EP_COUNT-1:0]              ep_tlast_i,
  input  usb_ep_pkg::byte_t [`USB_EP_COUNT-1:0] ep_tdata_i,
  output logic [`USB_EP_COUNT-1:0]              ep_tready_o,
  input  logic [`USB_EP_COUNT-1:0]              ep_parity_i,

  output logic                                  m_tvalid_o,
  input  logic                                  m_tready_i,
  output logic                                  m_tkeep_o,
  output logic                                  m_tlast_o,
  output usb_ep_pkg::byte_t                     m_tdata_o,
  output logic                                  parity_o
);

  usb_link_pkg::ep_num_t owner_q;
  usb_link_pkg::hs_t     hs_w;

  // Owner follows the last token, all ones means no owner
  always_ff @(posedge clock) begin
    if (rst_i) begin
      owner_q <= '1;
    end else if (token_i) begin
      owner_q <= token_ep_i;
    end
  end

  // ACK wins if both strobes show up together
  assign hs_w = ack_i     ? usb_link_pkg::HS_ACK :
                timeout_i ? usb_link_pkg::HS_TIMEOUT : usb_link_pkg::HS_NONE;

  // Steering, an unknown endpoint number matches no lane
  always_comb begin
    ep_selected_o = '0;
    ep_ack_o      = '0;
    ep_timeout_o  = '0;
    ep_tready_o   = '0;
    m_tvalid_o    = 1'b0;
    m_tkeep_o     = 1'b0;
    m_tlast_o     = 1'b0;
    m_tdata_o     = '0;
    parity_o      = 1'b0;
    for (int i = 0; i < `USB_EP_COUNT; i++) begin
      if (token_i && token_ep_i == usb_link_pkg::ep_num_t'(i)) begin
        ep_selected_o[i] = 1'b1;
      end
      if (owner_q == usb_link_pkg::ep_num_t'(i)) begin
        // Handshakes reach the owner as selected plus the result
        if (hs_w != usb_link_pkg::HS_NONE) begin
          ep_selected_o[i] = 1'b1;
        end
        ep_ack_o[i]     = hs_w == usb_link_pkg::HS_ACK;
        ep_timeout_o[i] = hs_w == usb_link_pkg::HS_TIMEOUT;
        ep_tready_o[i]  = m_tready_i;
        m_tvalid_o      = ep_tvalid_i[i];
        m_tkeep_o       = ep_tkeep_i[i];
        m_tlast_o       = ep_tlast_i[i];
        m_tdata_o       = ep_tdata_i[i];
        parity_o        = ep_parity_i[i];
      end
    end
  end

endmodule

// File: verilog/packet_fifo.sv
`include "usb_ep_settings.svh"

module packet_fifo (
  input  logic               clock,
  input  logic               rst_i,

  input  logic               save_i,
  input  logic               redo_i,
  input  logic               next_i,
  output usb_ep_pkg::level_t level_o,

  input  logic               s_tvalid_i,
  input  logic               s_tlast_i,
  input  usb_ep_pkg::byte_t  s_tdata_i,
  output logic               s_tready_o,

  output logic               m_tvalid_o,
  input  logic               m_tready_i,
  output logic               m_tlast_o,
  output usb_ep_pkg::byte_t  m_tdata_o
);

  localparam int ABITS = $clog2(`USB_EP_FIFO_DEPTH);
  localparam usb_ep_pkg::level_t DEPTH_LVL = usb_ep_pkg::level_t'(`USB_EP_FIFO_DEPTH);

  usb_ep_pkg::byte_t data_mem [`USB_EP_FIFO_DEPTH];
  logic              last_mem [`USB_EP_FIFO_DEPTH];

  // Write, committed, packet start and read pointers
  // All carry a wrap bit above the address
  usb_ep_pkg::level_t wr_q;
  usb_ep_pkg::level_t cm_q;
  usb_ep_pkg::level_t st_q;
  usb_ep_pkg::level_t rd_q;

  logic wr_w;
  logic avail_w;
  logic fetch_w;

  // Space is held until the packet is released by next
  assign level_o    = wr_q - st_q;
  assign s_tready_o = level_o < DEPTH_LVL;
  assign wr_w       = s_tvalid_i && s_tready_o;

  // Only committed bytes are offered to the reader
  assign avail_w = rd_q != cm_q;
  assign fetch_w = avail_w && (!m_tvalid_o || m_tready_i);

  // Byte store with its last flag
  always_ff @(posedge clock) begin
    if (wr_w) begin
      data_mem[wr_q[ABITS-1:0]] <= s_tdata_i;
      // A chunk cut at full length still ends with last
      last_mem[wr_q[ABITS-1:0]] <= s_tlast_i || save_i;
    end
  end

  // Write side pointers
  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_q <= '0;
      cm_q <= '0;
    end else if (wr_w) begin
      wr_q <= wr_q + 1'b1;
      // Save marks the byte being written as the chunk end
      if (save_i) begin
        cm_q <= wr_q + 1'b1;
      end
    end
  end

  // Read side pointers and output valid
  always_ff @(posedge clock) begin
    if (rst_i) begin
      rd_q       <= '0;
      st_q       <= '0;
      m_tvalid_o <= 1'b0;
    end else if (redo_i) begin
      // Replay from the start of the unacknowledged chunk
      rd_q       <= st_q;
      m_tvalid_o <= 1'b0;
    end else begin
      // Output register may already hold the next chunk's first byte
      if (next_i) begin
        st_q <= m_tvalid_o ? rd_q - 1'b1 : rd_q;
      end
      if (fetch_w) begin
        rd_q       <= rd_q + 1'b1;
        m_tvalid_o <= 1'b1;
      end else if (m_tready_i) begin
        m_tvalid_o <= 1'b0;
      end
    end
  end

  // Output payload register
  always_ff @(posedge clock) begin
    if (fetch_w) begin
      m_tdata_o <= data_mem[rd_q[ABITS-1:0]];
      m_tlast_o <= last_mem[rd_q[ABITS-1:0]];
    end
  end

endmodule

// File: verilog/usb_ep_pkg.sv
`include "usb_ep_settings.svh"

package usb_ep_pkg;

  // One data byte on either stream
  typedef logic [7:0] byte_t;

  // FIFO fill level, one extra bit so full and empty differ
  typedef logic [$clog2(`USB_EP_FIFO_DEPTH):0] level_t;

  // Byte index within one packet chunk
  typedef logic [$clog2(`USB_EP_MAX_PACKET)-1:0] count_t;

  // Source side of the endpoint
  typedef enum logic [1:0] {
    RX_HALT,
    RX_RECV,
    RX_FULL
  } rx_state_t;

  // Encoder side of the endpoint
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_SEND,
    TX_WAIT,
    TX_NONE,
    TX_REDO
  } tx_state_t;

endpackage

// File: verilog/usb_ep_settings.svh
`ifndef USB_EP_SETTINGS_SVH
`define USB_EP_SETTINGS_SVH

// Bytes per packet chunk, a power of two
// 512 for high speed, kept small for simulation
`define USB_EP_MAX_PACKET 8

// Bytes stored per endpoint FIFO
// Power of two, at least twice the packet length
`define USB_EP_FIFO_DEPTH 32

// Bulk IN endpoints sharing the encoder link
`define USB_EP_COUNT 2

`endif

// File: verilog/usb_in_top.sv
`include "usb_ep_settings.svh"

module usb_in_top (
  input  logic                     clock,
  input  logic                     rst_i,

  input  logic                     token_i,
  input  usb_link_pkg::ep_num_t    token_ep_i,
  input  logic                     ack_i,
  input  logic                     timeout_i,
  input  logic                     set_conf_i,
  input  logic                     clr_conf_i,

  input  logic                     ep0_s_tvalid_i,
  output logic                     ep0_s_tready_o,
  input  logic                     ep0_s_tlast_i,
  input  usb_ep_pkg::byte_t        ep0_s_tdata_i,

  input  logic                     ep1_s_tvalid_i,
  output logic                     ep1_s_tready_o,
  input  logic                     ep1_s_tlast_i,
  input  usb_ep_pkg::byte_t        ep1_s_tdata_i,

  output logic                     m_tvalid_o,
  input  logic                     m_tready_i,
  output logic                     m_tkeep_o,
  output logic                     m_tlast_o,
  output usb_ep_pkg::byte_t        m_tdata_o,
  output logic                     parity_o,

  output logic [`USB_EP_COUNT-1:0] ep_ready_o,
  output logic [`USB_EP_COUNT-1:0] stalled_o
);

  // Per endpoint lanes between endpoints and arbiter
  logic [`USB_EP_COUNT-1:0] sel_w, ack_w, tmo_w;
  logic [`USB_EP_COUNT-1:0] tvalid_w, tready_w, tkeep_w, tlast_w, parity_w;
  usb_ep_pkg::byte_t [`USB_EP_COUNT-1:0] tdata_w;

  ep_bulk_in ep0 (
    .clock     (clock),
    .rst_i     (rst_i),
    .set_conf_i(set_conf_i),
    .clr_conf_i(clr_conf_i),
    .selected_i(sel_w[0]),
    .ack_recv_i(ack_w[0]),
    .timedout_i(tmo_w[0]),
    .ep_ready_o(ep_ready_o[0]),
    .stalled_o (stalled_o[0]),
    .parity_o  (parity_w[0]),
    .s_tvalid_i(ep0_s_tvalid_i),
    .s_tready_o(ep0_s_tready_o),
    .s_tlast_i (ep0_s_tlast_i),
    .s_tdata_i (ep0_s_tdata_i),
    .m_tvalid_o(tvalid_w[0]),
    .m_tready_i(tready_w[0]),
    .m_tkeep_o (tkeep_w[0]),
    .m_tlast_o (tlast_w[0]),
    .m_tdata_o (tdata_w[0])
  );

  ep_bulk_in ep1 (
    .clock     (clock),
    .rst_i     (rst_i),
    .set_conf_i(set_conf_i),
    .clr_conf_i(clr_conf_i),
    .selected_i(sel_w[1]),
    .ack_recv_i(ack_w[1]),
    .timedout_i(tmo_w[1]),
    .ep_ready_o(ep_ready_o[1]),
    .stalled_o (stalled_o[1]),
    .parity_o  (parity_w[1]),
    .s_tvalid_i(ep1_s_tvalid_i),
    .s_tready_o(ep1_s_tready_o),
    .s_tlast_i (ep1_s_tlast_i),
    .s_tdata_i (ep1_s_tdata_i),
    .m_tvalid_o(tvalid_w[1]),
    .m_tready_i(tready_w[1]),
    .m_tkeep_o (tkeep_w[1]),
    .m_tlast_o (tlast_w[1]),
    .m_tdata_o (tdata_w[1])
  );

  ep_tx_arbiter u_arb (
    .clock        (clock),
    .rst_i        (rst_i),
    .token_i      (token_i),
    .token_ep_i   (token_ep_i),
    .ack_i        (ack_i),
    .timeout_i    (timeout_i),
    .ep_selected_o(sel_w),
    .ep_ack_o     (ack_w),
    .ep_timeout_o (tmo_w),
    .ep_tvalid_i  (tvalid_w),
    .ep_tkeep_i   (tkeep_w),
    .ep_tlast_i   (tlast_w),
    .ep_tdata_i   (tdata_w),
    .ep_tready_o  (tready_w),
    .ep_parity_i  (parity_w),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tkeep_o    (m_tkeep_o),
    .m_tlast_o    (m_tlast_o),
    .m_tdata_o    (m_tdata_o),
    .parity_o     (parity_o)
  );

endmodule

// File: verilog/usb_link_pkg.sv
package usb_link_pkg;

  // Endpoint number from an IN token
  typedef logic [3:0] ep_num_t;

  // Outcome of an IN transaction as seen by the host
  typedef enum logic [1:0] {
    HS_NONE,
    HS_ACK,
    HS_TIMEOUT
  } hs_t;

endpackage
